// ==== common/icache_cfg_pkg.sv ====
package icache_cfg_pkg;

	////////////////////////////////////////////////////////////////////////////
	// cache geometry
	////////////////////////////////////////////////////////////////////////////

	// byte addresses from the fetch unit
	localparam int ADDR_W = 32;

	// 16 byte lines, 64 of them
	localparam int OFFSET_W = 4;
	localparam int INDEX_W = 6;
	localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;
	localparam int NUM_LINES = 2 ** INDEX_W;

	// instruction words inside a line
	localparam int WORD_W = 32;
	localparam int WORDS_PER_LINE = 4;
	localparam int WORD_IDX_W = $clog2(WORDS_PER_LINE);

	// low address bits below the word select, always zero on the bus
	localparam int BYTE_SEL_W = OFFSET_W - WORD_IDX_W;

	////////////////////////////////////////////////////////////////////////////
	// width types
	////////////////////////////////////////////////////////////////////////////

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [OFFSET_W-1:0] offset_t;
	typedef logic [WORD_W-1:0] word_t;

	// word 0 sits in the low bits
	typedef logic [WORDS_PER_LINE-1:0][WORD_W-1:0] line_t;

endpackage

// ==== common/icache_types_pkg.sv ====
package icache_types_pkg;

	import icache_cfg_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// items passed between the cache stages
	////////////////////////////////////////////////////////////////////////////

	// one request issued by lookup, checked one cycle later
	typedef struct packed {
		logic valid;
		addr_t addr;
	} fetch_req_t;

	// tag array entry as read back, valid bit leading
	typedef struct packed {
		logic valid;
		tag_t tag;
	} stored_tag_t;

	// answer to the fetch unit
	typedef struct packed {
		addr_t addr;
		word_t instr;
	} fetch_resp_t;

	// line to bring in from memory
	typedef struct packed {
		tag_t tag;
		index_t index;
	} miss_req_t;

	// line install from the refill engine
	typedef struct packed {
		logic en;
		index_t index;
		tag_t tag;
		line_t line;
	} array_wr_t;

	////////////////////////////////////////////////////////////////////////////
	// refill engine states
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		IDLE,
		READ,
		INSTALL,
		DONE
	} refill_state_e;

endpackage

// ==== icache/icache_arrays.sv ====
`timescale 1ns/100ps

module icache_arrays (
	input  logic clock_i,
	input  logic rst_n_i,
	input  icache_cfg_pkg::index_t rd_index_i,
	input  icache_types_pkg::array_wr_t wr_i,
	output icache_types_pkg::stored_tag_t stored_o,
	output icache_cfg_pkg::line_t line_o
);

	import icache_cfg_pkg::*;

	logic [NUM_LINES-1:0] valid_q;
	tag_t tag_mem [NUM_LINES];
	line_t data_mem [NUM_LINES];

	logic rd_valid;
	tag_t rd_tag;

	////////////////////////////////////////////////////////////////////////////
	// valid bits
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			valid_q <= '0;
			rd_valid <= 1'b0;
		end
		else
		begin
			if (wr_i.en)
				valid_q[wr_i.index] <= 1'b1;
			rd_valid <= valid_q[rd_index_i];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// tag and data memories
	////////////////////////////////////////////////////////////////////////////

	// read before write on a shared index
	always_ff @(posedge clock_i)
	begin
		if (wr_i.en)
		begin
			tag_mem[wr_i.index] <= wr_i.tag;
			data_mem[wr_i.index] <= wr_i.line;
		end
		rd_tag <= tag_mem[rd_index_i];
		line_o <= data_mem[rd_index_i];
	end

	assign stored_o = '{valid: rd_valid, tag: rd_tag};

endmodule

// ==== icache/icache_lookup.sv ====
`timescale 1ns/100ps

module icache_lookup (
	input  logic clock_i,
	input  logic rst_n_i,
	input  logic req_en_i,
	input  icache_cfg_pkg::addr_t req_addr_i,
	input  logic flush_i,
	input  logic retire_i,
	input  logic squash_i,
	input  logic miss_pending_i,
	input  logic resolved_i,
	output logic req_ready_o,
	output icache_cfg_pkg::index_t rd_index_o,
	output icache_types_pkg::fetch_req_t issue_o
);

	import icache_cfg_pkg::*;

	// accepted but not yet retired, oldest at head
	addr_t q_addr [2];
	logic head;
	logic tail;
	logic [1:0] q_count;

	// out of reset for at least one cycle
	logic up;
	logic accept;
	logic replay_start;
	logic replay_second;
	logic issue_valid;
	logic issue_valid_q;
	addr_t issue_addr;
	addr_t issue_addr_q;

	assign req_ready_o = up && (q_count != 2'd2) && !miss_pending_i;
	assign accept = req_en_i && req_ready_o;

	// the refill is in, go again from the oldest entry
	assign replay_start = resolved_i && miss_pending_i && (q_count != 2'd0);

	always_comb
	begin
		issue_valid = 1'b0;
		issue_addr = req_addr_i;
		if (replay_start)
		begin
			issue_valid = 1'b1;
			issue_addr = q_addr[head];
		end
		else if (replay_second && !squash_i)
		begin
			issue_valid = 1'b1;
			issue_addr = q_addr[~head];
		end
		else if (accept && !squash_i)
		begin
			issue_valid = 1'b1;
		end
	end

	// arrays latch this index on the same edge as the issue register
	assign rd_index_o = issue_addr[OFFSET_W +: INDEX_W];

	always_ff @(posedge clock_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			up <= 1'b0;
			head <= 1'b0;
			tail <= 1'b0;
			q_count <= 2'd0;
			replay_second <= 1'b0;
			issue_valid_q <= 1'b0;
		end
		else
		begin
			up <= 1'b1;
			issue_valid_q <= issue_valid && !flush_i;
			if (flush_i)
			begin
				head <= 1'b0;
				tail <= 1'b0;
				q_count <= 2'd0;
			end
			else
			begin
				if (accept)
					tail <= ~tail;
				if (retire_i)
					head <= ~head;
				q_count <= q_count + {1'b0, accept} - {1'b0, retire_i};
			end
			// a full queue needs one more reissue after the oldest
			if (flush_i || squash_i)
				replay_second <= 1'b0;
			else if (replay_start)
				replay_second <= q_count[1];
			else if (replay_second)
				replay_second <= 1'b0;
		end
	end

	always_ff @(posedge clock_i)
	begin
		if (accept)
			q_addr[tail] <= req_addr_i;
		issue_addr_q <= issue_addr;
	end

	assign issue_o = '{valid: issue_valid_q, addr: issue_addr_q};

	a_no_overflow: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		q_count <= 2'd2);

	// the check stage only retires what was queued here
	a_retire_queued: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		retire_i |-> (q_count != 2'd0));

endmodule

// ==== icache/icache_hit_check.sv ====
`timescale 1ns/100ps

module icache_hit_check (
	input  logic clock_i,
	input  logic rst_n_i,
	input  logic flush_i,
	input  icache_types_pkg::fetch_req_t issue_i,
	input  icache_types_pkg::stored_tag_t stored_i,
	input  icache_cfg_pkg::line_t line_i,
	input  logic resolved_i,
	output logic resp_valid_o,
	output icache_types_pkg::fetch_resp_t resp_o,
	output logic retire_o,
	output logic squash_o,
	output logic miss_pending_o,
	output logic miss_start_o,
	output icache_types_pkg::miss_req_t miss_o
);

	import icache_cfg_pkg::*;

	tag_t req_tag;
	index_t req_index;
	logic check_en;
	logic hit;

	// refill engine is running, kept across a flush
	logic refill_busy;
	logic start_ok;
	logic start_arm;

	// hit stage, word select happens on the way out
	logic s1_valid;
	addr_t s1_addr;
	line_t s1_line;

	assign req_tag = issue_i.addr[ADDR_W-1 -: TAG_W];
	assign req_index = issue_i.addr[OFFSET_W +: INDEX_W];

	////////////////////////////////////////////////////////////////////////////
	// tag compare
	////////////////////////////////////////////////////////////////////////////

	assign check_en = issue_i.valid && !miss_pending_o && !flush_i;
	assign hit = stored_i.valid && (stored_i.tag == req_tag);

	assign retire_o = check_en && hit;
	assign squash_o = check_en && !hit;

	// the engine frees up in its resolved cycle
	assign start_ok = !refill_busy || resolved_i;

	always_ff @(posedge clock_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			s1_valid <= 1'b0;
			resp_valid_o <= 1'b0;
			miss_pending_o <= 1'b0;
			start_arm <= 1'b0;
			miss_start_o <= 1'b0;
			refill_busy <= 1'b0;
		end
		else
		begin
			s1_valid <= retire_o;
			resp_valid_o <= s1_valid && !flush_i;
			// start one cycle late so it never meets an older response
			start_arm <= squash_o && start_ok;
			miss_start_o <= start_arm;
			if (flush_i)
				miss_pending_o <= 1'b0;
			else if (squash_o)
				miss_pending_o <= 1'b1;
			else if (resolved_i)
				miss_pending_o <= 1'b0;
			if (squash_o && start_ok)
				refill_busy <= 1'b1;
			else if (resolved_i)
				refill_busy <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// payload
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock_i)
	begin
		s1_addr <= issue_i.addr;
		s1_line <= line_i;
		resp_o.addr <= s1_addr;
		resp_o.instr <= s1_line[s1_addr[OFFSET_W-1 -: WORD_IDX_W]];
		// a miss that has to wait for a busy engine comes back through replay
		if (squash_o && start_ok)
		begin
			miss_o.tag <= req_tag;
			miss_o.index <= req_index;
		end
	end

	a_resp_or_start: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		!(resp_valid_o && miss_start_o));

	// no second refill request before the current one resolves
	a_one_refill: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		miss_start_o |=> (!miss_start_o until_with resolved_i));

endmodule

// ==== icache/icache_refill.sv ====
`timescale 1ns/100ps

module icache_refill (
	input  logic clock_i,
	input  logic rst_n_i,
	input  logic miss_start_i,
	input  icache_types_pkg::miss_req_t miss_i,
	output logic wb_cyc_o,
	output logic wb_stb_o,
	output logic wb_we_o,
	output icache_cfg_pkg::addr_t wb_adr_o,
	input  icache_cfg_pkg::word_t wb_dat_i,
	input  logic wb_ack_i,
	output icache_types_pkg::array_wr_t wr_o,
	output logic resolved_o
);

	import icache_cfg_pkg::*;
	import icache_types_pkg::*;

	refill_state_e state;
	logic [WORD_IDX_W-1:0] word_cnt;
	logic last_word;

	// line being fetched and its collected words
	tag_t line_tag;
	index_t line_index;
	line_t line_buf;

	assign last_word = (word_cnt == WORD_IDX_W'(WORDS_PER_LINE - 1));

	////////////////////////////////////////////////////////////////////////////
	// Wishbone classic read cycles
	////////////////////////////////////////////////////////////////////////////

	assign wb_we_o = 1'b0;
	assign wb_adr_o = {line_tag, line_index, word_cnt, {BYTE_SEL_W{1'b0}}};

	always_ff @(posedge clock_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			state <= IDLE;
			word_cnt <= '0;
			wb_cyc_o <= 1'b0;
			wb_stb_o <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (miss_start_i)
					begin
						word_cnt <= '0;
						wb_cyc_o <= 1'b1;
						wb_stb_o <= 1'b1;
						state <= READ;
					end
				end
				READ:
				begin
					if (wb_stb_o && wb_ack_i)
					begin
						// stb goes low for one cycle between words
						wb_stb_o <= 1'b0;
						if (last_word)
						begin
							wb_cyc_o <= 1'b0;
							state <= INSTALL;
						end
						else
							word_cnt <= word_cnt + 1'b1;
					end
					else if (!wb_stb_o)
						wb_stb_o <= 1'b1;
				end
				INSTALL:
					state <= DONE;
				default:
					state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clock_i)
	begin
		if (state == IDLE && miss_start_i)
		begin
			line_tag <= miss_i.tag;
			line_index <= miss_i.index;
		end
		if (state == READ && wb_stb_o && wb_ack_i)
			line_buf[word_cnt] <= wb_dat_i;
	end

	////////////////////////////////////////////////////////////////////////////
	// install and report
	////////////////////////////////////////////////////////////////////////////

	assign wr_o = '{en: (state == INSTALL), index: line_index, tag: line_tag, line: line_buf};
	assign resolved_o = (state == DONE);

	// a slow slave sees the same address until it acks
	a_adr_stable: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		(wb_stb_o && !wb_ack_i) |=> (wb_stb_o && $stable(wb_adr_o)));

endmodule

// ==== rtl/icache_top.sv ====
`timescale 1ns/100ps

module icache_top (
	input  logic clock_i,
	input  logic rst_n_i,
	input  logic flush_i,
	// fetch side
	input  logic req_en_i,
	input  icache_cfg_pkg::addr_t req_addr_i,
	output logic req_ready_o,
	output logic resp_valid_o,
	output icache_types_pkg::fetch_resp_t resp_o,
	// memory side
	output logic wb_cyc_o,
	output logic wb_stb_o,
	output logic wb_we_o,
	output icache_cfg_pkg::addr_t wb_adr_o,
	input  icache_cfg_pkg::word_t wb_dat_i,
	input  logic wb_ack_i
);

	import icache_cfg_pkg::*;
	import icache_types_pkg::*;

	index_t rd_index;
	fetch_req_t issue;
	stored_tag_t stored;
	line_t line;
	logic retire;
	logic squash;
	logic miss_pending;
	logic miss_start;
	miss_req_t miss;
	logic resolved;
	array_wr_t arr_wr;

	////////////////////////////////////////////////////////////////////////////
	// input side and storage
	////////////////////////////////////////////////////////////////////////////

	icache_lookup u_lookup (
		.clock_i(clock_i),
		.rst_n_i(rst_n_i),
		.req_en_i(req_en_i),
		.req_addr_i(req_addr_i),
		.flush_i(flush_i),
		.retire_i(retire),
		.squash_i(squash),
		.miss_pending_i(miss_pending),
		.resolved_i(resolved),
		.req_ready_o(req_ready_o),
		.rd_index_o(rd_index),
		.issue_o(issue)
	);

	icache_arrays u_arrays (
		.clock_i(clock_i),
		.rst_n_i(rst_n_i),
		.rd_index_i(rd_index),
		.wr_i(arr_wr),
		.stored_o(stored),
		.line_o(line)
	);

	////////////////////////////////////////////////////////////////////////////
	// hit check and refill
	////////////////////////////////////////////////////////////////////////////

	icache_hit_check u_hit_check (
		.clock_i(clock_i),
		.rst_n_i(rst_n_i),
		.flush_i(flush_i),
		.issue_i(issue),
		.stored_i(stored),
		.line_i(line),
		.resolved_i(resolved),
		.resp_valid_o(resp_valid_o),
		.resp_o(resp_o),
		.retire_o(retire),
		.squash_o(squash),
		.miss_pending_o(miss_pending),
		.miss_start_o(miss_start),
		.miss_o(miss)
	);

	icache_refill u_refill (
		.clock_i(clock_i),
		.rst_n_i(rst_n_i),
		.miss_start_i(miss_start),
		.miss_i(miss),
		.wb_cyc_o(wb_cyc_o),
		.wb_stb_o(wb_stb_o),
		.wb_we_o(wb_we_o),
		.wb_adr_o(wb_adr_o),
		.wb_dat_i(wb_dat_i),
		.wb_ack_i(wb_ack_i),
		.wr_o(arr_wr),
		.resolved_o(resolved)
	);

endmodule

// ==== tb/wb_mem_model.sv ====
`timescale 1ns/100ps

module wb_mem_model (
	input  logic clock_i,
	input  logic rst_n_i,
	input  logic cyc_i,
	input  logic stb_i,
	input  logic we_i,
	input  icache_cfg_pkg::addr_t adr_i,
	input  logic [1:0] delay_i,
	output icache_cfg_pkg::word_t dat_o,
	output logic ack_o,
	output logic [31:0] reads_o
);

	import icache_cfg_pkg::*;

	logic [1:0] wait_cnt;

	// contents follow the address, no storage needed
	function automatic word_t mem_word(input addr_t adr);
		return adr ^ 32'h5A5A_5A5A;
	endfunction

	// registered ack, delay_i extra wait cycles per read
	always_ff @(posedge clock_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			ack_o <= 1'b0;
			dat_o <= '0;
			wait_cnt <= '0;
			reads_o <= '0;
		end
		else if (ack_o)
		begin
			ack_o <= 1'b0;
			wait_cnt <= '0;
		end
		else if (cyc_i && stb_i && !we_i)
		begin
			if (wait_cnt == delay_i)
			begin
				ack_o <= 1'b1;
				dat_o <= mem_word(adr_i);
				reads_o <= reads_o + 1;
			end
			else
				wait_cnt <= wait_cnt + 1'b1;
		end
		else
			wait_cnt <= '0;
	end

endmodule

// ==== tb/icache_tb.sv ====
`timescale 1ns/100ps

module icache_tb;

	import icache_cfg_pkg::*;
	import icache_types_pkg::*;

	localparam int WAIT_LIMIT = 200;
	localparam int PAT_WORDS = 192;
	localparam logic [31:0] SEED = 32'h0127_4251;

	// one outstanding fetch and what it should return
	typedef struct packed {
		fetch_resp_t resp;
		logic must_hit;
		logic [31:0] accept_edge;
	} expect_t;

	logic clock_i = 1'b0;
	logic rst_n_i;
	logic flush_i;
	logic req_en_i;
	addr_t req_addr_i;
	logic req_ready_o;
	logic resp_valid_o;
	fetch_resp_t resp_o;
	logic wb_cyc_o;
	logic wb_stb_o;
	logic wb_we_o;
	addr_t wb_adr_o;
	word_t wb_dat_i;
	logic wb_ack_i;

	logic [1:0] ack_delays [64];
	logic [1:0] ack_delay;
	logic [31:0] mem_reads;
	logic [31:0] reads_mark = '0;
	logic [31:0] edge_count = '0;

	word_t pattern [PAT_WORDS];
	expect_t exp_q [$];
	expect_t head_item;
	addr_t line_base;
	int word_k = 0;

	// expected cache contents, direct mapped by line index
	logic tag_known [NUM_LINES];
	tag_t tag_model [NUM_LINES];
	addr_t refill_q [$];

	int mismatch_count = 0;
	int fail_count = 0;
	int timeout_count = 0;

	always #50 clock_i = ~clock_i;

	always @(posedge clock_i)
		edge_count <= edge_count + 1;

	icache_top dut0 (
		.clock_i(clock_i),
		.rst_n_i(rst_n_i),
		.flush_i(flush_i),
		.req_en_i(req_en_i),
		.req_addr_i(req_addr_i),
		.req_ready_o(req_ready_o),
		.resp_valid_o(resp_valid_o),
		.resp_o(resp_o),
		.wb_cyc_o(wb_cyc_o),
		.wb_stb_o(wb_stb_o),
		.wb_we_o(wb_we_o),
		.wb_adr_o(wb_adr_o),
		.wb_dat_i(wb_dat_i),
		.wb_ack_i(wb_ack_i)
	);

	// new delay after every completed read
	assign ack_delay = ack_delays[mem_reads[5:0]];

	wb_mem_model mem0 (
		.clock_i(clock_i),
		.rst_n_i(rst_n_i),
		.cyc_i(wb_cyc_o),
		.stb_i(wb_stb_o),
		.we_i(wb_we_o),
		.adr_i(wb_adr_o),
		.delay_i(ack_delay),
		.dat_o(wb_dat_i),
		.ack_o(wb_ack_i),
		.reads_o(mem_reads)
	);

	////////////////////////////////////////////////////////////////////////////
	// compare tasks and the closing report
	////////////////////////////////////////////////////////////////////////////

	task automatic check_resp(input fetch_resp_t exp, input fetch_resp_t act);
		if (act !== exp)
		begin
			mismatch_count++;
			$display("mismatch at %0t: resp_o expected %h/%h got %h/%h", $time,
				exp.addr, exp.instr, act.addr, act.instr);
		end
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp)
		begin
			mismatch_count++;
			$display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_addr(input string name, input addr_t exp, input addr_t act);
		if (act !== exp)
		begin
			mismatch_count++;
			$display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int unsigned exp,
		input int unsigned act);
		if (act != exp)
		begin
			mismatch_count++;
			$display("mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			mismatch_count++;
			$display("mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	task finish_run;
		$display("errors: %0d mismatches, %0d other failures, %0d timeouts",
			mismatch_count, fail_count, timeout_count);
		if (mismatch_count == 0 && fail_count == 0 && timeout_count == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// monitors, sampled mid cycle
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clock_i)
	begin
		if (rst_n_i && resp_valid_o)
		begin
			if (exp_q.size() == 0)
			begin
				fail_count++;
				$display("unexpected response at %0t for address %h", $time, resp_o.addr);
			end
			else
			begin
				head_item = exp_q.pop_front();
				check_resp(head_item.resp, resp_o);
				if (head_item.must_hit)
					check_count("hit latency", 2, edge_count - head_item.accept_edge);
			end
		end
	end

	// every refill reads word 0 to 3 of the line that the oldest miss needs
	always @(negedge clock_i)
	begin
		if (wb_cyc_o && wb_we_o)
		begin
			fail_count++;
			$display("write cycle on the Wishbone bus at %0t", $time);
		end
		if (wb_cyc_o && wb_stb_o && wb_ack_i)
		begin
			if (word_k == 0)
			begin
				if (refill_q.size() == 0)
				begin
					fail_count++;
					$display("refill read at %0t for %h with no missing fetch", $time,
						wb_adr_o);
				end
				else
					line_base = refill_q.pop_front();
			end
			check_addr("wb_adr_o", line_base + addr_t'(word_k * 4), wb_adr_o);
			word_k = (word_k + 1) % WORDS_PER_LINE;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus, all tasks start and end 5 ns after a rising edge
	////////////////////////////////////////////////////////////////////////////

	// a line the cache does not hold yet has to come in over the bus
	task automatic note_fetch(input addr_t fetch_addr);
		index_t line_idx;
		tag_t line_tag;
		line_idx = fetch_addr[OFFSET_W +: INDEX_W];
		line_tag = fetch_addr[ADDR_W-1 -: TAG_W];
		if (!tag_known[line_idx] || tag_model[line_idx] != line_tag)
		begin
			tag_known[line_idx] = 1'b1;
			tag_model[line_idx] = line_tag;
			refill_q.push_back({fetch_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}});
		end
	endtask

	task automatic fetch_word(input addr_t fetch_addr, input word_t word, input logic must_hit);
		expect_t item;
		int waited;
		logic accepted;
		check_word("pattern word", fetch_addr ^ 32'h5A5A_5A5A, word);
		req_en_i = 1'b1;
		req_addr_i = fetch_addr;
		waited = 0;
		accepted = 1'b0;
		while (!accepted && waited < WAIT_LIMIT)
		begin
			@(negedge clock_i);
			accepted = req_ready_o;
			if (accepted)
			begin
				item.resp.addr = fetch_addr;
				item.resp.instr = word;
				item.must_hit = must_hit;
				item.accept_edge = edge_count + 1;
				exp_q.push_back(item);
				note_fetch(fetch_addr);
			end
			@(posedge clock_i);
			#5;
			waited++;
		end
		req_en_i = 1'b0;
		if (!accepted)
		begin
			$display("timeout at %0t: req_ready_o stayed low for %h", $time, fetch_addr);
			timeout_count++;
		end
	endtask

	// whatever is outstanding at the flush edge is dropped
	task automatic flush_after(input int unsigned cycles);
		repeat (cycles)
		begin
			@(posedge clock_i);
			#5;
		end
		flush_i = 1'b1;
		@(posedge clock_i);
		#5;
		flush_i = 1'b0;
		exp_q.delete();
	endtask

	task automatic drain_responses;
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < WAIT_LIMIT)
		begin
			@(posedge clock_i);
			#5;
			waited++;
		end
		if (exp_q.size() != 0)
		begin
			$display("timeout at %0t: %0d responses never arrived", $time, exp_q.size());
			timeout_count++;
		end
	endtask

	task automatic wait_bus_idle;
		int waited;
		waited = 0;
		while (wb_cyc_o && waited < WAIT_LIMIT)
		begin
			@(posedge clock_i);
			#5;
			waited++;
		end
		if (wb_cyc_o)
		begin
			$display("timeout at %0t: Wishbone cycle never ended", $time);
			timeout_count++;
		end
	endtask

	task automatic idle_gap(input int unsigned cycles, input int unsigned exp_reads);
		drain_responses();
		wait_bus_idle();
		repeat (cycles)
		begin
			@(posedge clock_i);
			#5;
		end
		check_count("wishbone reads", exp_reads, mem_reads - reads_mark);
		check_count("missing lines not refilled", 0, refill_q.size());
		reads_mark = mem_reads;
	endtask

	initial
	begin
		int i;
		int idx;
		logic running;
		word_t cmd;
		word_t arg_a;
		word_t arg_w;
		rst_n_i = 1'b0;
		flush_i = 1'b0;
		req_en_i = 1'b0;
		req_addr_i = '0;
		ack_delays[0] = 2'($urandom(SEED) % 4);
		for (i = 1; i < 64; i++)
			ack_delays[i] = 2'($urandom % 4);
		for (i = 0; i < NUM_LINES; i++)
			tag_known[i] = 1'b0;
		for (i = 0; i < PAT_WORDS; i++)
			pattern[i] = '0;
		$readmemh("tb/icache_patterns.txt", pattern);

		repeat (4) @(posedge clock_i);
		#5;
		rst_n_i = 1'b1;
		// first cycle out of reset
		check_flag("req_ready_o", 1'b0, req_ready_o);
		check_flag("resp_valid_o", 1'b0, resp_valid_o);
		check_flag("wb_cyc_o", 1'b0, wb_cyc_o);
		check_flag("wb_stb_o", 1'b0, wb_stb_o);

		// 1 fetch, 2 fetch that hits, 3 flush, 4 gap, 0 end
		idx = 0;
		running = 1'b1;
		while (running)
		begin
			cmd = pattern[idx];
			arg_a = pattern[idx + 1];
			arg_w = pattern[idx + 2];
			case (cmd)
				32'd0:
					running = 1'b0;
				32'd1:
					fetch_word(arg_a, arg_w, 1'b0);
				32'd2:
					fetch_word(arg_a, arg_w, 1'b1);
				32'd3:
					flush_after(arg_a);
				32'd4:
					idle_gap(arg_a, arg_w);
				default:
				begin
					fail_count++;
					$display("unknown command %h in the pattern file", cmd);
					running = 1'b0;
				end
			endcase
			idx += 3;
			if (idx + 2 >= PAT_WORDS)
				running = 1'b0;
			if (timeout_count != 0)
				running = 1'b0;
		end
		finish_run();
	end

endmodule

// ==== tb/icache_patterns.txt ====
// columns: command, address or cycle count, word or read count (all hex)
// 1 fetch, 2 fetch that must hit in two cycles, 3 flush after n cycles, 4 gap then reads, 0 end
4 00000003 00000000
// first miss, refill starts at 0x100
1 00000104 5A5A5B5E
4 00000006 00000004
2 00000100 5A5A5B5A
2 00000108 5A5A5B52
2 0000010C 5A5A5B56
4 00000004 00000000
// same index, other tag
1 00001108 5A5A4B52
4 00000006 00000004
2 0000110C 5A5A4B56
4 00000004 00000000
1 00000100 5A5A5B5A
4 00000006 00000004
// misses with a younger request in flight
1 00000200 5A5A585A
1 00000204 5A5A585E
4 00000006 00000004
1 00000308 5A5A5952
1 00000404 5A5A5E5E
4 00000006 00000008
1 00000600 5A5A5C5A
1 00000108 5A5A5B52
4 00000006 00000004
// flushes
2 00000100 5A5A5B5A
2 00000104 5A5A5B5E
3 00000000 00000000
4 00000004 00000000
1 00000700 5A5A5D5A
1 00000104 5A5A5B5E
3 00000003 00000000
4 00000006 00000004
2 00000700 5A5A5D5A
2 00000708 5A5A5D52
2 00000104 5A5A5B5E
4 00000004 00000000
0 00000000 00000000

// ==== build.f ====
common/icache_cfg_pkg.sv
common/icache_types_pkg.sv
icache/icache_arrays.sv
icache/icache_lookup.sv
icache/icache_hit_check.sv
icache/icache_refill.sv
rtl/icache_top.sv
tb/wb_mem_model.sv
tb/icache_tb.sv
